/* verilog/ts_mem_pkg.sv */
// Constants shared by the memory-side blocks of the TS2068-style core.
// Holds the flat memory map, the host download index codes and the
// length of the optional DOCK file header.

package ts_mem_pkg;

    // ========================================================
    // Flat external memory
    // ========================================================
    localparam int mem_addr_width = 20;

    // Region bases in the byte-wide store
    localparam logic [mem_addr_width-1:0] rom_base     = 20'h10000; // Main ROM 16K
    localparam logic [mem_addr_width-1:0] ext_rom_base = 20'h14000; // Ext ROM 8K
    localparam logic [mem_addr_width-1:0] esx_rom_base = 20'h16000; // ESXDOS ROM 8K
    localparam logic [mem_addr_width-1:0] divmmc_base  = 20'h20000; // 16 pages of 8K
    localparam logic [mem_addr_width-1:0] dock_base    = 20'h40000;
    localparam logic [mem_addr_width-1:0] tape_base    = 20'h80000; // Upper half

    // ========================================================
    // Host downloads
    // ========================================================
    localparam logic [7:0] idx_rom  = 8'd0;
    localparam logic [7:0] idx_dock = 8'd1;
    localparam logic [7:0] idx_tape = 8'd2;

    // DCK files with a header carry 9 extra bytes in front
    localparam int dock_header_len = 9;

endpackage

/* verilog/download_decoder.sv */
// First stage of the memory path. Sorts host (ioctl) download bytes into
// ROM, cartridge and tape images and relocates them into the flat store.
// Also strips a DOCK header and keeps the cartridge state for the mapper.

`timescale 1ns/1ps

module download_decoder (
    input  logic                                    clk_sys,
    input  logic                                    reset_n,
    input  logic                                    ioctl_download,
    input  logic [7:0]                              ioctl_index,
    input  logic                                    ioctl_wr,
    input  logic [24:0]                             ioctl_addr,
    input  logic [7:0]                              ioctl_dout,
    input  logic [31:0]                             ioctl_filesize,
    input  logic                                    cart_remove,
    output logic                                    dl_active,
    output logic                                    dl_wr,
    output logic [ts_mem_pkg::mem_addr_width-1:0]   dl_addr,
    output logic [7:0]                              dl_data,
    output logic                                    tape_dl_active,
    output logic [2:0]                              dock_blocks,
    output logic                                    dock_loaded,
    output logic                                    dock_header,
    output logic [18:0]                             tape_last
);
    import ts_mem_pkg::*;

    logic        rom_dl, dock_dl, tape_dl;
    logic        dock_dl_q;     // Delayed copy for start and end edges
    logic        hdr_now;
    logic        dock_keep;
    logic [15:0] dock_off;

    assign rom_dl  = ioctl_download && (ioctl_index == idx_rom);
    assign dock_dl = ioctl_download && (ioctl_index == idx_dock);
    assign tape_dl = ioctl_download && (ioctl_index == idx_tape);

    // Header flag is valid already in the first cycle of the download
    assign hdr_now   = (dock_dl && !dock_dl_q) ? |ioctl_filesize[3:0] : dock_header;
    assign dock_keep = !hdr_now || (ioctl_addr >= 25'(dock_header_len));
    assign dock_off  = hdr_now ? ioctl_addr[15:0] - 16'(dock_header_len) : ioctl_addr[15:0];

    // ========================================================
    // Control and cartridge state
    // ========================================================
    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            dl_active      <= 1'b0;
            dl_wr          <= 1'b0;
            tape_dl_active <= 1'b0;
            dock_dl_q      <= 1'b0;
            dock_header    <= 1'b0;
            dock_loaded    <= 1'b0;
            dock_blocks    <= 3'd0;
            tape_last      <= 19'd0;
        end else begin
            dl_active      <= rom_dl || dock_dl;
            tape_dl_active <= tape_dl;
            dock_dl_q      <= dock_dl;
            dl_wr          <= ioctl_wr && (rom_dl || tape_dl || (dock_dl && dock_keep));

            if (cart_remove)
                dock_header <= 1'b0;
            if (dock_dl && !dock_dl_q)
                dock_header <= |ioctl_filesize[3:0];    // Size not a multiple of 16

            // Highest 8K block written so far
            if (dock_dl && ioctl_wr && dock_keep)
                dock_blocks <= dock_off[15:13];

            if (dock_dl_q && !dock_dl)
                dock_loaded <= 1'b1;
            else if (cart_remove)
                dock_loaded <= 1'b0;

            if (tape_dl && ioctl_wr)
                tape_last <= ioctl_addr[18:0];
        end
    end

    // Relocated write address and data
    always_ff @(posedge clk_sys) begin
        dl_data <= ioctl_dout;
        if (dock_dl)
            dl_addr <= dock_base + mem_addr_width'(dock_off);
        else if (tape_dl)
            dl_addr <= tape_base + mem_addr_width'(ioctl_addr[18:0]);
        else
            dl_addr <= rom_base + mem_addr_width'(ioctl_addr[15:0]);
    end

endmodule

/* verilog/mem_mapper.sv */
// Second stage of the memory path. Picks the download or the CPU as the
// source of the next access, maps CPU addresses onto the flat store and
// blocks CPU writes to ROM. Unloaded cartridge reads are marked to float.
// All outputs are registered, one cycle from input to store request.

`timescale 1ns/1ps

module mem_mapper (
    input  logic                                    clk_sys,
    input  logic                                    reset_n,
    input  logic                                    dl_active,
    input  logic                                    dl_wr,
    input  logic [ts_mem_pkg::mem_addr_width-1:0]   dl_addr,
    input  logic [7:0]                              dl_data,
    input  logic [2:0]                              dock_blocks,
    input  logic                                    dock_loaded,
    input  logic [15:0]                             mem_a,
    input  logic [7:0]                              mem_d,
    input  logic                                    mem_rd,
    input  logic                                    mem_wr,
    input  logic                                    mem_b,
    input  logic [7:0]                              mem_m,
    input  logic                                    mapped,
    input  logic                                    ramcs,
    input  logic [3:0]                              page,
    output logic [ts_mem_pkg::mem_addr_width-1:0]   st_addr,
    output logic [7:0]                              st_din,
    output logic                                    st_we,
    output logic                                    st_re,
    output logic                                    st_float
);
    import ts_mem_pkg::*;

    logic [2:0]                blk;         // 8K block of the CPU address
    logic                      low16k;
    logic [mem_addr_width-1:0] cpu_addr;
    logic                      cpu_wr_ok;
    logic                      cpu_float;

    assign blk    = mem_a[15:13];
    assign low16k = (mem_a[15:14] == 2'b00);

    // ========================================================
    // CPU address decode in priority order
    // ========================================================
    always_comb begin
        cpu_wr_ok = mapped && (blk == 3'd1);    // DivMMC RAM window at 0x2000
        cpu_float = 1'b0;
        if (low16k && mapped) begin
            if (ramcs)
                cpu_addr = divmmc_base + mem_addr_width'({page, mem_a[12:0]});
            else
                cpu_addr = esx_rom_base + mem_addr_width'(mem_a[12:0]);
        end else if (mem_m[blk]) begin
            if (mem_b) begin
                cpu_addr = ext_rom_base + mem_addr_width'(mem_a[12:0]);
            end else begin
                cpu_addr  = dock_base + mem_addr_width'(mem_a);
                cpu_float = !dock_loaded || (blk > dock_blocks);
            end
        end else if (low16k) begin
            cpu_addr = rom_base + mem_addr_width'(mem_a[13:0]);
        end else begin
            cpu_addr  = mem_addr_width'(mem_a);  // Home RAM
            cpu_wr_ok = 1'b1;
        end
    end

    // Control with downloads ahead of the CPU
    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            st_we    <= 1'b0;
            st_re    <= 1'b0;
            st_float <= 1'b0;
        end else if (dl_active || dl_wr) begin
            st_we    <= dl_wr;
            st_re    <= 1'b0;
            st_float <= 1'b0;
        end else begin
            st_we    <= mem_wr && cpu_wr_ok;
            st_re    <= mem_rd;
            st_float <= mem_rd && cpu_float;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (dl_active || dl_wr) begin
            st_addr <= dl_addr;
            st_din  <= dl_data;
        end else begin
            st_addr <= cpu_addr;
            st_din  <= mem_d;
        end
    end

endmodule

/* verilog/mem_store.sv */
// Third stage of the memory path. Byte-wide synchronous RAM standing in
// for the external SDRAM. The main port owns every cycle with a request;
// the tape port is served in idle cycles and answers with a toggle on tp_ack.

`timescale 1ns/1ps

module mem_store #(
    parameter int addr_width = ts_mem_pkg::mem_addr_width
) (
    input  logic                                    clk_sys,
    input  logic                                    reset_n,
    input  logic [ts_mem_pkg::mem_addr_width-1:0]   st_addr,
    input  logic [7:0]                              st_din,
    input  logic                                    st_we,
    input  logic                                    st_re,
    input  logic                                    st_float,
    input  logic                                    tp_rd,
    input  logic [ts_mem_pkg::mem_addr_width-1:0]   tp_addr,
    output logic [7:0]                              mem_q,
    output logic [7:0]                              tp_dout,
    output logic                                    tp_ack
);

    logic [7:0] ram [0:(2**addr_width)-1];
    logic       main_busy;
    logic       tp_served;      // Current tape request already answered
    logic       tp_serve;

    assign main_busy = st_we || st_re;
    assign tp_serve  = tp_rd && !tp_served && !main_busy;

    // ========================================================
    // Array and data paths
    // ========================================================
    always_ff @(posedge clk_sys) begin
        if (st_we)
            ram[st_addr[addr_width-1:0]] <= st_din;

        if (st_re) begin
            if (st_float)
                mem_q <= 8'hFF;     // Empty cartridge slot
            else
                mem_q <= ram[st_addr[addr_width-1:0]];
        end

        if (tp_serve)
            tp_dout <= ram[tp_addr[addr_width-1:0]];
    end

    // Tape port handshake
    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            tp_ack    <= 1'b0;
            tp_served <= 1'b0;
        end else begin
            if (tp_serve) begin
                tp_ack    <= ~tp_ack;
                tp_served <= 1'b1;
            end else if (!tp_rd) begin
                tp_served <= 1'b0;  // Re-armed once the request drops
            end
        end
    end

endmodule

/* verilog/tape_fetch.sv */
// Tape playback fetcher. Walks the stored tape image one byte per player
// request. The player toggles tape_req; the byte is read from the store
// over the tp_rd/tp_ack pair and handed back with tape_data_ack = tape_req.

`timescale 1ns/1ps

module tape_fetch #(
    parameter int tape_addr_width = 19
) (
    input  logic                                    clk_sys,
    input  logic                                    reset_n,
    input  logic                                    tape_dl_active,
    input  logic [tape_addr_width-1:0]              tape_last,
    input  logic                                    tape_req,
    input  logic                                    tp_ack,
    input  logic [7:0]                              tp_dout,
    output logic                                    tp_rd,
    output logic [ts_mem_pkg::mem_addr_width-1:0]   tp_addr,
    output logic [7:0]                              tape_byte,
    output logic                                    tape_data_ack,
    output logic                                    tape_restart
);
    import ts_mem_pkg::*;

    logic [tape_addr_width:0] play_ptr;     // One extra bit to run past the end
    logic                     ack_seen;
    logic                     ack_toggled;
    logic                     tape_dl_q;

    assign ack_toggled = tp_ack ^ ack_seen;
    assign tp_addr     = tape_base + mem_addr_width'(play_ptr[tape_addr_width-1:0]);

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            play_ptr      <= '0;
            tp_rd         <= 1'b0;
            ack_seen      <= 1'b0;
            tape_dl_q     <= 1'b0;
            tape_restart  <= 1'b0;
            tape_data_ack <= tape_req;  // No request pending
        end else begin
            ack_seen     <= tp_ack;
            tape_dl_q    <= tape_dl_active;
            tape_restart <= tape_dl_active && !tape_dl_q;

            if (tape_dl_active) begin
                play_ptr <= '0;         // Rewind for a new image
                tp_rd    <= 1'b0;
            end else if (tp_rd && ack_toggled) begin
                tp_rd         <= 1'b0;
                tape_data_ack <= tape_req;
                play_ptr      <= play_ptr + 1'b1;
            end else if (!tp_rd && (tape_req != tape_data_ack)
                         && (play_ptr <= {1'b0, tape_last})) begin
                tp_rd <= 1'b1;
            end
        end
    end

    // Byte goes out together with the acknowledge
    always_ff @(posedge clk_sys) begin
        if (tp_rd && ack_toggled)
            tape_byte <= tp_dout;
    end

endmodule

/* verilog/ts_mem_top.sv */
// Memory side of the TS2068-style core. Chains the download decoder, the
// address mapper and the byte store, with the tape fetcher reading the
// store in idle cycles. CPU reads return on mem_q two cycles after mem_rd.

`timescale 1ns/1ps

module ts_mem_top #(
    parameter int addr_width = ts_mem_pkg::mem_addr_width
) (
    input  logic        clk_sys,
    input  logic        reset_n,
    input  logic        ioctl_download,
    input  logic [7:0]  ioctl_index,
    input  logic        ioctl_wr,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic [31:0] ioctl_filesize,
    input  logic        cart_remove,
    input  logic [15:0] mem_a,
    input  logic [7:0]  mem_d,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  logic        mem_b,
    input  logic [7:0]  mem_m,
    input  logic        mapped,
    input  logic        ramcs,
    input  logic [3:0]  page,
    input  logic        tape_req,
    output logic [7:0]  mem_q,
    output logic [7:0]  tape_byte,
    output logic        tape_data_ack,
    output logic        tape_restart,
    output logic        dock_loaded,
    output logic        dock_header
);
    import ts_mem_pkg::*;

    localparam int tape_addr_width = mem_addr_width - 1;   // Tape owns the upper half

    // ========================================================
    // Stage wiring
    // ========================================================
    logic                       dl_active, dl_wr, tape_dl_active;
    logic [mem_addr_width-1:0]  dl_addr;
    logic [7:0]                 dl_data;
    logic [2:0]                 dock_blocks;
    logic [tape_addr_width-1:0] tape_last;
    logic [mem_addr_width-1:0]  st_addr, tp_addr;
    logic [7:0]                 st_din, tp_dout;
    logic                       st_we, st_re, st_float;
    logic                       tp_rd, tp_ack;

    download_decoder download_decoder_i (
        .clk_sys, .reset_n, .ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr,
        .ioctl_dout, .ioctl_filesize, .cart_remove, .dl_active, .dl_wr, .dl_addr,
        .dl_data, .tape_dl_active, .dock_blocks, .dock_loaded, .dock_header, .tape_last
    );

    mem_mapper mem_mapper_i (
        .clk_sys, .reset_n, .dl_active, .dl_wr, .dl_addr, .dl_data, .dock_blocks,
        .dock_loaded, .mem_a, .mem_d, .mem_rd, .mem_wr, .mem_b, .mem_m, .mapped,
        .ramcs, .page, .st_addr, .st_din, .st_we, .st_re, .st_float
    );

    mem_store #(.addr_width(addr_width)) mem_store_i (
        .clk_sys, .reset_n, .st_addr, .st_din, .st_we, .st_re, .st_float,
        .tp_rd, .tp_addr, .mem_q, .tp_dout, .tp_ack
    );

    tape_fetch #(.tape_addr_width(tape_addr_width)) tape_fetch_i (
        .clk_sys, .reset_n, .tape_dl_active, .tape_last, .tape_req, .tp_ack,
        .tp_dout, .tp_rd, .tp_addr, .tape_byte, .tape_data_ack, .tape_restart
    );

endmodule

/* tests/ts_mem_tb.sv */
// Self-checking testbench for the memory side of the TS2068-style core.
// Loads ROM, DOCK and tape images over the host download port, then runs
// CPU reads and writes and the tape player handshake against the store.

`timescale 1ns/1ps

module ts_mem_tb;
    import ts_mem_pkg::*;

    localparam int wait_limit = 200;    // Cycles per bounded wait

    logic        clk_sys, reset_n;
    logic        ioctl_download, ioctl_wr, cart_remove;
    logic [7:0]  ioctl_index, ioctl_dout;
    logic [24:0] ioctl_addr;
    logic [31:0] ioctl_filesize;
    logic [15:0] mem_a;
    logic [7:0]  mem_d, mem_m;
    logic        mem_rd, mem_wr, mem_b, mapped, ramcs, tape_req;
    logic [3:0]  page;
    logic [7:0]  mem_q, tape_byte;
    logic        tape_data_ack, tape_restart, dock_loaded, dock_header;

    // Reference images filled from $random
    logic [7:0]  rom_img  [0:32767];
    logic [7:0]  dock_img [0:16392];   // 9 header bytes plus two 8K blocks
    logic [7:0]  tape_img [0:19];
    integer      seed = 58250;
    int          cnt;

    ts_mem_top #(.addr_width(mem_addr_width)) ts_mem_top_i (.*);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // ========================================================
    // Helpers
    // ========================================================
    task automatic fail_and_stop(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_value(input string test_name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else
            fail_and_stop($sformatf("CHECK FAILED %s: expected 0x%02h, actual 0x%02h",
                                    test_name, expected, actual));
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #2;     // Inputs change shortly after the edge
    endtask

    task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
        mem_a  = addr;
        mem_rd = 1'b1;
        next_cycle();
        mem_rd = 1'b0;
        next_cycle();
        data = mem_q;   // Two cycles after the request
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        mem_a  = addr;
        mem_d  = data;
        mem_wr = 1'b1;
        next_cycle();
        mem_wr = 1'b0;
        next_cycle();
    endtask

    task automatic read_and_check(input string test_name, input logic [15:0] addr,
                                  input logic [7:0] expected);
        logic [7:0] data;
        cpu_read(addr, data);
        check_value($sformatf("%s @%04h", test_name, addr), expected, data);
    endtask

    function automatic logic [7:0] image_byte(input logic [7:0] index, input int offset);
        case (index)
            idx_rom:  return rom_img[offset];
            idx_dock: return dock_img[offset];
            default:  return tape_img[offset];
        endcase
    endfunction

    // One byte per cycle like the host SPI link at full speed
    task automatic host_download(input logic [7:0] index, input int size);
        int cycles;
        ioctl_index    = index;
        ioctl_filesize = size;
        ioctl_download = 1'b1;
        next_cycle();
        if (index == idx_tape) begin
            cycles = 0;
            while (!tape_restart && cycles < wait_limit) begin
                next_cycle();
                cycles++;
            end
            if (!tape_restart)
                fail_and_stop("No tape_restart pulse after the tape download started");
        end
        for (int i = 0; i < size; i++) begin
            ioctl_addr = 25'(i);
            ioctl_dout = image_byte(index, i);
            ioctl_wr   = 1'b1;
            next_cycle();
        end
        ioctl_wr       = 1'b0;
        ioctl_download = 1'b0;
        repeat (6) next_cycle();    // Drain the write pipeline
    endtask

    // ========================================================
    // Test sequence
    // ========================================================
    initial begin
        reset_n = 1'b0;
        {ioctl_download, ioctl_wr, cart_remove, ioctl_index, ioctl_dout} = '0;
        ioctl_addr = '0;
        ioctl_filesize = '0;
        {mem_a, mem_d, mem_m, mem_rd, mem_wr, mem_b} = '0;
        {mapped, ramcs, page, tape_req} = '0;
        for (int i = 0; i < 32768; i++)
            rom_img[i] = 8'($random(seed));
        for (int i = 0; i < 16393; i++)
            dock_img[i] = 8'($random(seed));
        for (int i = 0; i < 20; i++)
            tape_img[i] = 8'($random(seed));

        repeat (16) @(posedge clk_sys);
        #2 reset_n = 1'b1;
        check_value("reset dock_loaded", 8'(1'b0), 8'(dock_loaded));
        check_value("reset tape_data_ack", 8'(tape_req), 8'(tape_data_ack));

        // ROM load, protection and the ESXDOS overlay
        host_download(idx_rom, 32768);
        for (int a = 0; a < 16'h4000; a += 16'h0123)
            read_and_check("rom read", 16'(a), rom_img[a]);
        read_and_check("rom read", 16'h3FFF, rom_img[16'h3FFF]);
        cpu_write(16'h1000, ~rom_img[16'h1000]);
        read_and_check("rom protect", 16'h1000, rom_img[16'h1000]);
        mapped = 1'b1;
        for (int a = 0; a < 16'h2000; a += 16'h0377)
            read_and_check("esxdos rom", 16'(a), rom_img[16'h6000 + a]);

        // Mapped ROM window write and home RAM
        cpu_write(16'h0100, ~rom_img[16'h6100]);
        read_and_check("divmmc rom protect", 16'h0100, rom_img[16'h6100]);
        mapped = 1'b0;
        cpu_write(16'h4000, 8'h5A);
        cpu_write(16'hC000, 8'hC3);
        read_and_check("home ram", 16'h4000, 8'h5A);
        read_and_check("home ram", 16'hC000, 8'hC3);

        // DOCK image with a header
        host_download(idx_dock, 16393);
        check_value("dock_header", 8'h01, 8'(dock_header));
        check_value("dock_loaded", 8'h01, 8'(dock_loaded));
        mem_m = 8'h01;
        for (int a = 0; a < 16'h2000; a += 16'h0291)
            read_and_check("dock block 0", 16'(a), dock_img[a + 9]);
        mem_m = 8'h07;
        read_and_check("dock block 1", 16'h2345, dock_img[16'h2345 + 9]);
        read_and_check("dock beyond end", 16'h4010, 8'hFF);

        // Cartridge removal and the extended ROM
        cart_remove = 1'b1;
        next_cycle();
        cart_remove = 1'b0;
        next_cycle();
        check_value("cart removed", 8'h00, 8'(dock_loaded));
        read_and_check("empty dock", 16'h0010, 8'hFF);
        mem_b = 1'b1;
        read_and_check("ext rom", 16'h0123, rom_img[16'h4123]);
        read_and_check("ext rom", 16'h3ABC, rom_img[16'h5ABC]);
        mem_m = 8'h00;
        mem_b = 1'b0;

        // DivMMC RAM pages
        mapped = 1'b1;
        ramcs  = 1'b1;
        page   = 4'd4;
        cpu_write(16'h2000, 8'h44);
        page = 4'd3;
        cpu_write(16'h2000, 8'h33);
        read_and_check("divmmc page 3", 16'h2000, 8'h33);
        page = 4'd4;
        read_and_check("divmmc page 4", 16'h2000, 8'h44);
        mapped = 1'b0;
        ramcs  = 1'b0;

        // ========================================================
        // Tape playback alongside CPU traffic
        // ========================================================
        host_download(idx_tape, 20);
        for (int i = 0; i < 20; i++) begin
            tape_req = ~tape_req;
            cnt = 0;
            while (tape_data_ack != tape_req && cnt < wait_limit) begin
                read_and_check("ram during tape", 16'h4000, 8'h5A);
                cnt++;
            end
            if (tape_data_ack != tape_req)
                fail_and_stop($sformatf("Tape byte %0d was never acknowledged", i));
            check_value($sformatf("tape byte %0d", i), tape_img[i], tape_byte);
        end

        // Past the end the request must stay open
        tape_req = ~tape_req;
        for (int i = 0; i < wait_limit; i++) begin
            next_cycle();
            assert (tape_data_ack != tape_req) else
                fail_and_stop("A tape request past the end of the image was acknowledged");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* files.f */
verilog/ts_mem_pkg.sv
verilog/download_decoder.sv
verilog/mem_mapper.sv
verilog/mem_store.sv
verilog/tape_fetch.sv
verilog/ts_mem_top.sv
tests/ts_mem_tb.sv

/* Bender.yml */
package:
  name: ts_mem

sources:
  - verilog/ts_mem_pkg.sv
  - verilog/download_decoder.sv
  - verilog/mem_mapper.sv
  - verilog/mem_store.sv
  - verilog/tape_fetch.sv
  - verilog/ts_mem_top.sv
  - target: test
    files:
      - tests/ts_mem_tb.sv
